//--- vlog.f
+incdir+hdl
+incdir+tb
hdl/frame_pkg.sv
hdl/frame_sequencer.sv
hdl/object_table.sv
hdl/pixel_scan.sv
hdl/sprite_masks.sv
hdl/frame_renderer.sv
tb/tb_frame_renderer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_frame_renderer -f vlog.f

output=$(./obj_dir/Vtb_frame_renderer)
echo "$output"

if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

//--- tb/frame_model.svh
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// Expected writes as {x, y, colour} in stream order
logic [17:0] exp_q [$];

function automatic logic ship_fg(input logic [3:0] code, input int row, input int col);
	string m;
	case (code)
		4'b0001: m = {".#.", "###", "#.#"}; // Up
		4'b0101: m = {"###", ".##", "..#"};
		4'b0100: m = {"##.", ".##", "##."}; // Right
		4'b0110: m = {"..#", ".##", "###"};
		4'b0010: m = {"#.#", "###", ".#."}; // Down
		4'b1010: m = {"#..", "##.", "###"};
		4'b1000: m = {".##", "##.", ".##"}; // Left
		4'b1001: m = {"###", "##.", "#.."};
		default: m = ".........";
	endcase
	if (row < 1 || row > 3 || col < 1 || col > 3)
		return 1'b0;
	return m[(row - 1) * 3 + col - 1] == "#";
endfunction

function automatic logic rock_fg(input int row, input int col);
	string d;
	d = {"..#..", ".###.", "##.##", ".###.", "..#.."};
	return d[row * 5 + col] == "#";
endfunction

function automatic logic [17:0] pack_write(input int x, input int y, input logic fg);
	logic [7:0] px;
	logic [6:0] py;
	px = x[7:0]; // Screen address wraps
	py = y[6:0];
	return {px, py, fg ? 3'(`COLOUR_FG) : 3'(`COLOUR_BG)};
endfunction

task automatic build_expected();
	int ox, oy;
	exp_q.delete();
	for (int y = 0; y < `SCREEN_H; y++)
		for (int x = 0; x < `SCREEN_W; x++)
			exp_q.push_back(pack_write(x, y, 1'b0));
	for (int r = 0; r < `SPRITE_SIZE; r++)
		for (int c = 0; c < `SPRITE_SIZE; c++)
			exp_q.push_back(pack_write(`SHIP_X + c, `SHIP_Y + r, ship_fg(ship_heading, r, c)));
	for (int s = 0; s < `NUM_SLOTS; s++) begin
		if (!asteroid_en[s])
			continue;
		ox = int'(asteroid_x[s]) - `SPRITE_OFFSET;
		oy = int'(asteroid_y[s]) - `SPRITE_OFFSET;
		for (int r = 0; r < `SPRITE_SIZE; r++)
			for (int c = 0; c < `SPRITE_SIZE; c++)
				exp_q.push_back(pack_write(ox + c, oy + r, rock_fg(r, c)));
	end
	for (int s = 0; s < `NUM_SLOTS; s++)
		if (bullet_en[s])
			exp_q.push_back(pack_write(bullet_x[s], bullet_y[s], 1'b1));
endtask

`endif

//--- tb/tb_frame_renderer.sv
`timescale 1ns/10ps
`include "frame_params.svh"

module tb_frame_renderer;

	logic clk, resetn, frame_start;
	frame_pkg::heading_t ship_heading;
	frame_pkg::coord_x_t [`NUM_SLOTS-1:0] asteroid_x, bullet_x;
	frame_pkg::coord_y_t [`NUM_SLOTS-1:0] asteroid_y, bullet_y;
	logic [`NUM_SLOTS-1:0] asteroid_en, bullet_en;
	logic plot, busy, frame_done;
	frame_pkg::coord_x_t pix_x;
	frame_pkg::coord_y_t pix_y;
	frame_pkg::colour_t pix_colour;

	string test_name;
	int errors, frames, done_count, write_count;
	logic frame_open, hung;
	logic [17:0] got;

	`include "frame_model.svh"

	frame_renderer DUT (.*);

	always #10 clk = ~clk;

	// Pixel stream checker
	always @(posedge clk) begin
		if (resetn && plot) begin
			got = {pix_x, pix_y, pix_colour};
			write_count++;
			if (!frame_open || exp_q.size() == 0) begin
				errors++;
				$display("%s: pixel write outside the expected stream", test_name);
			end else begin
				if (got !== exp_q[0]) begin
					errors++;
					$display("** Error: %s: expected x=%0d y=%0d c=%0d, actual x=%0d y=%0d c=%0d",
						test_name, exp_q[0][17:10], exp_q[0][9:3], exp_q[0][2:0],
						pix_x, pix_y, pix_colour);
				end
				exp_q.delete(0);
			end
		end
		if (resetn && frame_done) begin
			done_count++;
			if (!frame_open || busy || exp_q.size() != 0) begin
				errors++;
				$display("%s: frame_done with no frame open, busy high or %0d writes missing",
					test_name, exp_q.size());
			end
			frame_open = 1'b0;
		end
	end

	task automatic finish_run();
		$display("Errors: %0d, frames: %0d, frame_done pulses: %0d", errors, frames, done_count);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic check_idle(input int n);
		if (hung)
			return;
		repeat (n) begin
			@(negedge clk);
			if (plot || busy || frame_done) begin
				errors++;
				$display("** Error: %s: expected plot/busy/done 000, actual %b%b%b",
					test_name, plot, busy, frame_done);
			end
		end
	endtask

	task automatic randomize_objects();
		for (int s = 0; s < `NUM_SLOTS; s++) begin
			case ($urandom % 4)
				0: begin
					asteroid_x[s] = 8'($urandom % 3); // Cell wraps past 0
					asteroid_y[s] = 7'($urandom % 3);
				end
				1: begin
					asteroid_x[s] = 8'(`SCREEN_W - 2 + $urandom % 3);
					asteroid_y[s] = 7'(`SCREEN_H - 2 + $urandom % 3);
				end
				default: begin
					asteroid_x[s] = 8'($urandom);
					asteroid_y[s] = 7'($urandom);
				end
			endcase
			bullet_x[s] = 8'($urandom);
			bullet_y[s] = 7'($urandom);
		end
		asteroid_en = 8'($urandom);
		bullet_en = 8'($urandom);
	endtask

	// Called on a falling edge; disturb changes inputs mid frame
	task automatic run_frame(input logic disturb);
		int cycles;
		if (hung)
			return;
		build_expected();
		write_count = 0;
		frame_open = 1'b1;
		frames++;
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		if (!busy) begin
			errors++;
			$display("** Error: %s: expected busy 1, actual 0", test_name);
		end
		if (disturb) begin
			repeat (10) @(negedge clk);
			randomize_objects();
			ship_heading = 4'($urandom);
			frame_start = 1'b1; // Must be ignored
			@(negedge clk);
			frame_start = 1'b0;
		end
		cycles = 0;
		while (frame_open && cycles < 40000) begin
			@(negedge clk);
			cycles++;
		end
		if (frame_open) begin
			errors++;
			$display("%s: no frame_done within 40000 cycles", test_name);
			hung = 1'b1;
		end
	endtask

	initial begin
		logic [3:0] codes [9];
		codes = '{4'b0001, 4'b0101, 4'b0100, 4'b0110, 4'b0010, 4'b1010, 4'b1000, 4'b1001,
			4'b1111};
		void'($urandom(32'h0e10ec39));
		clk = 1'b0;
		resetn = 1'b0;
		frame_start = 1'b0;
		ship_heading = 4'b0001;
		asteroid_x = '0;
		asteroid_y = '0;
		asteroid_en = '0;
		bullet_x = '0;
		bullet_y = '0;
		bullet_en = '0;
		frame_open = 1'b0;
		hung = 1'b0;
		test_name = "reset_idle";
		repeat (4) @(negedge clk);
		resetn = 1'b1;
		check_idle(20);

		test_name = "erase_only";
		run_frame(1'b0);
		if (write_count != 19225) begin
			errors++;
			$display("** Error: %s: expected 19225 writes, actual %0d", test_name, write_count);
		end
		check_idle(5);

		test_name = "headings";
		foreach (codes[i]) begin
			ship_heading = codes[i];
			run_frame(1'b0);
			check_idle(3);
		end

		test_name = "random_objects";
		repeat (10) begin
			randomize_objects();
			ship_heading = codes[$urandom % 9];
			run_frame(1'b0);
			check_idle(3);
		end

		test_name = "snapshot_busy";
		randomize_objects();
		run_frame(1'b1);
		check_idle(30);

		if (done_count != frames) begin
			errors++;
			$display("** Error: done_count: expected %0d, actual %0d", frames, done_count);
		end
		finish_run();
	end

endmodule

//--- hdl/frame_renderer.sv
`timescale 1ns/10ps
`include "frame_params.svh"

module frame_renderer (
	input  logic clk,
	input  logic resetn,
	input  logic frame_start,
	input  frame_pkg::heading_t ship_heading,
	input  frame_pkg::coord_x_t [`NUM_SLOTS-1:0] asteroid_x,
	input  frame_pkg::coord_y_t [`NUM_SLOTS-1:0] asteroid_y,
	input  logic [`NUM_SLOTS-1:0] asteroid_en,
	input  frame_pkg::coord_x_t [`NUM_SLOTS-1:0] bullet_x,
	input  frame_pkg::coord_y_t [`NUM_SLOTS-1:0] bullet_y,
	input  logic [`NUM_SLOTS-1:0] bullet_en,
	output logic plot,
	output frame_pkg::coord_x_t pix_x,
	output frame_pkg::coord_y_t pix_y,
	output frame_pkg::colour_t pix_colour,
	output logic busy,
	output logic frame_done
);

	frame_pkg::pass_t pass;
	frame_pkg::heading_t heading;
	frame_pkg::coord_x_t origin_x;
	frame_pkg::coord_y_t origin_y;
	frame_pkg::cell_t cell_col, cell_row;
	logic capture, scan_run, next_slot;
	logic cell_last, slot_en, slot_last;

	frame_sequencer u_seq (
		.clk(clk),
		.resetn(resetn),
		.frame_start(frame_start),
		.cell_last(cell_last),
		.slot_en(slot_en),
		.slot_last(slot_last),
		.pass(pass),
		.capture(capture),
		.scan_run(scan_run),
		.next_slot(next_slot),
		.plot(plot),
		.busy(busy),
		.frame_done(frame_done)
	);

	object_table u_objects (
		.clk(clk),
		.resetn(resetn),
		.capture(capture),
		.next_slot(next_slot),
		.pass(pass),
		.ship_heading(ship_heading),
		.asteroid_x(asteroid_x),
		.asteroid_y(asteroid_y),
		.asteroid_en(asteroid_en),
		.bullet_x(bullet_x),
		.bullet_y(bullet_y),
		.bullet_en(bullet_en),
		.heading(heading),
		.origin_x(origin_x),
		.origin_y(origin_y),
		.slot_en(slot_en),
		.slot_last(slot_last)
	);

	pixel_scan u_scan (
		.clk(clk),
		.resetn(resetn),
		.scan_run(scan_run),
		.pass(pass),
		.origin_x(origin_x),
		.origin_y(origin_y),
		.cell_col(cell_col),
		.cell_row(cell_row),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.cell_last(cell_last)
	);

	sprite_masks u_masks (
		.pass(pass),
		.heading(heading),
		.cell_col(cell_col),
		.cell_row(cell_row),
		.pix_colour(pix_colour)
	);

endmodule

//--- hdl/sprite_masks.sv
`timescale 1ns/10ps
`include "frame_params.svh"

module sprite_masks (
	input  frame_pkg::pass_t pass,
	input  frame_pkg::heading_t heading,
	input  frame_pkg::cell_t cell_col,
	input  frame_pkg::cell_t cell_row,
	output frame_pkg::colour_t pix_colour
);

	logic [8:0] ship_mask; // Rows 1..3, columns 1..3, MSB first
	logic [2:0] ship_row;
	logic [4:0] rock_row;
	logic ship_on, rock_on, fg;

	always_comb begin
		case (heading)
			4'b0001: ship_mask = 9'b010_111_101; // Up
			4'b0101: ship_mask = 9'b111_011_001;
			4'b0100: ship_mask = 9'b110_011_110; // Right
			4'b0110: ship_mask = 9'b001_011_111;
			4'b0010: ship_mask = 9'b101_111_010; // Down
			4'b1010: ship_mask = 9'b100_110_111;
			4'b1000: ship_mask = 9'b011_110_011; // Left
			4'b1001: ship_mask = 9'b111_110_100;
			default: ship_mask = '0;
		endcase
	end

	assign ship_row = (cell_row == 3'd1) ? ship_mask[8:6] :
			  (cell_row == 3'd2) ? ship_mask[5:3] : ship_mask[2:0];

	// Outer ring of the ship cell stays background
	assign ship_on = (cell_row inside {[3'd1:3'd3]}) && (cell_col inside {[3'd1:3'd3]}) &&
			 ship_row[2'd3 - cell_col[1:0]];

	// Diamond
	always_comb begin
		case (cell_row)
			3'd0, 3'd4: rock_row = 5'b00100;
			3'd1, 3'd3: rock_row = 5'b01110;
			3'd2: rock_row = 5'b11011;
			default: rock_row = '0;
		endcase
	end

	assign rock_on = (cell_col <= 3'd4) && rock_row[3'd4 - cell_col];

	always_comb begin
		case (pass)
			frame_pkg::PASS_SHIP: fg = ship_on;
			frame_pkg::PASS_ASTEROID: fg = rock_on;
			frame_pkg::PASS_BULLET: fg = 1'b1;
			default: fg = 1'b0; // Erase and idle
		endcase
	end

	assign pix_colour = fg ? frame_pkg::colour_t'(`COLOUR_FG) : frame_pkg::colour_t'(`COLOUR_BG);

endmodule

//--- hdl/pixel_scan.sv
`timescale 1ns/10ps
`include "frame_params.svh"

module pixel_scan (
	input  logic clk,
	input  logic resetn,
	input  logic scan_run,
	input  frame_pkg::pass_t pass,
	input  frame_pkg::coord_x_t origin_x,
	input  frame_pkg::coord_y_t origin_y,
	output frame_pkg::cell_t cell_col,
	output frame_pkg::cell_t cell_row,
	output frame_pkg::coord_x_t pix_x,
	output frame_pkg::coord_y_t pix_y,
	output logic cell_last
);

	frame_pkg::coord_x_t x_cnt, x_last;
	frame_pkg::coord_y_t y_cnt, y_last;

	// Region size per pass
	always_comb begin
		case (pass)
			frame_pkg::PASS_ERASE: begin
				x_last = frame_pkg::coord_x_t'(`SCREEN_W - 1);
				y_last = frame_pkg::coord_y_t'(`SCREEN_H - 1);
			end
			frame_pkg::PASS_SHIP, frame_pkg::PASS_ASTEROID: begin
				x_last = frame_pkg::coord_x_t'(`SPRITE_SIZE - 1);
				y_last = frame_pkg::coord_y_t'(`SPRITE_SIZE - 1);
			end
			default: begin
				x_last = '0; // Single pixel
				y_last = '0;
			end
		endcase
	end

	assign cell_last = (x_cnt == x_last) && (y_cnt == y_last);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (!scan_run) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (x_cnt == x_last) begin
			x_cnt <= '0;
			y_cnt <= (y_cnt == y_last) ? '0 : y_cnt + 1'b1; // Back to 0 for next region
		end else begin
			x_cnt <= x_cnt + 1'b1;
		end
	end

	assign cell_col = x_cnt[2:0];
	assign cell_row = y_cnt[2:0];

	assign pix_x = origin_x + x_cnt; // Wraps at 8 bits
	assign pix_y = origin_y + y_cnt; // Wraps at 7 bits

endmodule

//--- hdl/object_table.sv
`timescale 1ns/10ps
`include "frame_params.svh"

module object_table (
	input  logic clk,
	input  logic resetn,
	input  logic capture,
	input  logic next_slot,
	input  frame_pkg::pass_t pass,
	input  frame_pkg::heading_t ship_heading,
	input  frame_pkg::coord_x_t [`NUM_SLOTS-1:0] asteroid_x,
	input  frame_pkg::coord_y_t [`NUM_SLOTS-1:0] asteroid_y,
	input  logic [`NUM_SLOTS-1:0] asteroid_en,
	input  frame_pkg::coord_x_t [`NUM_SLOTS-1:0] bullet_x,
	input  frame_pkg::coord_y_t [`NUM_SLOTS-1:0] bullet_y,
	input  logic [`NUM_SLOTS-1:0] bullet_en,
	output frame_pkg::heading_t heading,
	output frame_pkg::coord_x_t origin_x,
	output frame_pkg::coord_y_t origin_y,
	output logic slot_en,
	output logic slot_last
);

	frame_pkg::coord_x_t [`NUM_SLOTS-1:0] ast_x, bul_x;
	frame_pkg::coord_y_t [`NUM_SLOTS-1:0] ast_y, bul_y;
	logic [`NUM_SLOTS-1:0] ast_en, bul_en;
	frame_pkg::slot_t slot;

	// Object snapshot
	always_ff @(posedge clk) begin
		if (capture) begin
			ast_x <= asteroid_x;
			ast_y <= asteroid_y;
			bul_x <= bullet_x;
			bul_y <= bullet_y;
			heading <= ship_heading;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ast_en <= '0;
			bul_en <= '0;
			slot <= '0;
		end else if (capture) begin
			ast_en <= asteroid_en;
			bul_en <= bullet_en;
			slot <= '0;
		end else if (next_slot) begin
			slot <= slot + 1'b1; // Wraps to 0 for the bullet pass
		end
	end

	assign slot_last = (slot == frame_pkg::slot_t'(`NUM_SLOTS - 1));

	always_comb begin
		origin_x = '0;
		origin_y = '0;
		slot_en = 1'b0;
		case (pass)
			frame_pkg::PASS_SHIP: begin
				origin_x = frame_pkg::coord_x_t'(`SHIP_X);
				origin_y = frame_pkg::coord_y_t'(`SHIP_Y);
				slot_en = 1'b1; // Ship always drawn
			end
			frame_pkg::PASS_ASTEROID: begin
				origin_x = ast_x[slot] - frame_pkg::coord_x_t'(`SPRITE_OFFSET);
				origin_y = ast_y[slot] - frame_pkg::coord_y_t'(`SPRITE_OFFSET);
				slot_en = ast_en[slot];
			end
			frame_pkg::PASS_BULLET: begin
				origin_x = bul_x[slot];
				origin_y = bul_y[slot];
				slot_en = bul_en[slot];
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer (
	input  logic clk,
	input  logic resetn,
	input  logic frame_start,
	input  logic cell_last,
	input  logic slot_en,
	input  logic slot_last,
	output frame_pkg::pass_t pass,
	output logic capture,
	output logic scan_run,
	output logic next_slot,
	output logic plot,
	output logic busy,
	output logic frame_done
);

	logic slot_pass;
	logic slot_done;

	assign slot_pass = (pass == frame_pkg::PASS_ASTEROID) || (pass == frame_pkg::PASS_BULLET);

	// A disabled slot is skipped in a single cycle
	assign slot_done = !slot_en || cell_last;

	assign capture = (pass == frame_pkg::PASS_IDLE) && frame_start;
	assign busy = (pass != frame_pkg::PASS_IDLE);

	// slot_en is forced high in the ship pass by the object table
	assign scan_run = (pass == frame_pkg::PASS_ERASE) || slot_en;
	assign plot = scan_run;

	assign next_slot = slot_pass && slot_done;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pass <= frame_pkg::PASS_IDLE;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (pass)
				frame_pkg::PASS_IDLE: begin
					if (frame_start)
						pass <= frame_pkg::PASS_ERASE;
				end
				frame_pkg::PASS_ERASE: begin
					if (cell_last)
						pass <= frame_pkg::PASS_SHIP;
				end
				frame_pkg::PASS_SHIP: begin
					if (cell_last)
						pass <= frame_pkg::PASS_ASTEROID;
				end
				frame_pkg::PASS_ASTEROID: begin
					if (slot_done && slot_last)
						pass <= frame_pkg::PASS_BULLET;
				end
				frame_pkg::PASS_BULLET: begin
					if (slot_done && slot_last) begin
						pass <= frame_pkg::PASS_IDLE;
						frame_done <= 1'b1; // Same cycle busy drops
					end
				end
				default: pass <= frame_pkg::PASS_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/frame_pkg.sv
package frame_pkg;

	typedef logic [7:0] coord_x_t; // Screen column
	typedef logic [6:0] coord_y_t; // Screen row
	typedef logic [2:0] colour_t; // One bit per RGB channel

	// Ship heading as direction bits
	typedef logic [3:0] heading_t;

	typedef logic [2:0] slot_t;
	typedef logic [2:0] cell_t; // Position inside a 5x5 cell

	// Drawing passes, in frame order
	typedef enum logic [2:0] {
		PASS_IDLE,
		PASS_ERASE,
		PASS_SHIP,
		PASS_ASTEROID,
		PASS_BULLET
	} pass_t;

endpackage

//--- hdl/frame_params.svh
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

// Frame buffer geometry
`define SCREEN_W 160
`define SCREEN_H 120

// Sprite cell edge and the shift from object centre to cell corner
`define SPRITE_SIZE 5
`define SPRITE_OFFSET 2

// Asteroid slots and bullet slots
`define NUM_SLOTS 8

// Ship cell corner at screen centre
`define SHIP_X 79
`define SHIP_Y 59

`define COLOUR_FG 7 // White
`define COLOUR_BG 0 // Black

`endif
